// ==== divider_input.txt ====
# name dividend divisor expected_quotient (32-bit hex, quotient has 10 fraction bits)
one_third 00000001 00000003 00000155
seven_halves 00000007 00000002 00000E00
six_by_three 00000006 00000003 00000800
hundred_by_four 00000064 00000004 00006400
one_by_one 00000001 00000001 00000400
two_thirds 00000002 00000003 000002AB
zero_dividend 00000000 00000005 00000000
one_seventh 00000001 00000007 00000092
million_by_three 000F4240 00000003 14585555
three_by_thousand 00000003 000003E8 00000003
max_by_one 001FFFFF 00000001 7FFFFC00
pi_approx 00000163 00000071 00000C91
large_by_odd 0001E240 00000315 000271E3
ten_by_ten 0000000A 0000000A 00000400
one_quarter 00000001 00000004 00000100
one_tenth 00000001 0000000A 00000066
tiny_by_max 00000001 7FFFFFFF 00000000
neg_dividend FFFFFFF9 00000002 FFFFF200
neg_divisor 00000001 FFFFFFFD FFFFFEAB
both_neg FFFFFFFF FFFFFFFD 00000155
neg_million FFF0BDC0 00000003 EBA7AAAB
neg_pi 00000163 FFFFFF8F FFFFF36F
both_neg_pi FFFFFE9D FFFFFF8F 00000C91
neg_seventh FFFFFFFF 00000007 FFFFFF6E
zero_neg_divisor 00000000 FFFFFFFB 00000000
min_result FFE00000 00000001 80000000
neg_divisor_hundred 00000064 FFFFFFFC FFFF9C00
both_neg_large FFFE1DC0 FFFFFCEB 000271E3
neg_large_dividend 88CA6C00 001E8480 FFF06000
min_divisor 004C4B40 80000000 FFFFFFFE
round_at_half 00000001 00000800 00000001
round_below_even 00000001 00000802 00000000
round_below_odd 00000001 00000801 00000000
round_above_odd 00000001 000007FF 00000001
round_half_five 00000005 00000800 00000003
round_below_five 00000005 00000802 00000002
round_half_neg FFFFFFFB 00000800 FFFFFFFD
round_below_neg FFFFFFFB 00000802 FFFFFFFE
round_half_three 00000003 00000800 00000002
round_up_quarter 00000007 00001000 00000002
round_down_quarter 00000009 00001000 00000002

// ==== divider_params.svh ====
`ifndef DIVIDER_PARAMS_SVH
`define DIVIDER_PARAMS_SVH

// operand and quotient width
`define D_WIDTH 32

// fraction bits in the quotient
`define Q_BITS 10

// entries in each FIFO
`define FIFO_DEPTH 8

`endif

// ==== divider_pkg.sv ====
`default_nettype none

`include "divider_params.svh"

package divider_pkg;

    // one division request as it sits in the input FIFO
    typedef struct packed {
        logic signed [`D_WIDTH-1:0] dividend;
        logic signed [`D_WIDTH-1:0] divisor;
    } operand_pair_t;

    // fixed-point result with Q_BITS fraction bits
    typedef logic signed [`D_WIDTH-1:0] quotient_t;

endpackage

`default_nettype wire

// ==== divider_tb.sv ====
`default_nettype none

`include "divider_params.svh"

module divider_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_tests = 64;
    localparam int wait_limit = 2000; // cycles per handshake wait
    localparam int fill_limit = 5000; // cycles for the input FIFO to fill
    localparam int stall_run = 2 * (`D_WIDTH + `Q_BITS + 2); // well over one division

    logic clock;
    logic reset;
    logic in_wr_en;
    logic signed [`D_WIDTH-1:0] in_dividend;
    logic signed [`D_WIDTH-1:0] in_divisor;
    logic in_full;
    logic out_rd_en;
    logic signed [`D_WIDTH-1:0] out_quotient;
    logic out_empty;

    string names [max_tests];
    logic [`D_WIDTH-1:0] dividends [max_tests];
    logic [`D_WIDTH-1:0] divisors [max_tests];
    logic [`D_WIDTH-1:0] expected_q [max_tests];
    int num_tests;

    int pass_count;
    int fail_count;
    bit aborted;
    integer seed;

    divider_top dut (
        .clock(clock),
        .reset(reset),
        .in_wr_en(in_wr_en),
        .in_dividend(in_dividend),
        .in_divisor(in_divisor),
        .in_full(in_full),
        .out_rd_en(out_rd_en),
        .out_quotient(out_quotient),
        .out_empty(out_empty)
    );

    always #50 clock = ~clock;

    task automatic load_vectors();
        integer fd;
        integer code;
        logic [8*128-1:0] header;
        logic [8*32-1:0] name_buf;
        logic [`D_WIDTH-1:0] a;
        logic [`D_WIDTH-1:0] b;
        logic [`D_WIDTH-1:0] q;
        num_tests = 0;
        fd = $fopen("divider_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file divider_input.txt");
            aborted = 1'b1;
            fail_count++;
        end else begin
            code = $fgets(header, fd); // column header
            code = $fscanf(fd, "%s %h %h %h\n", name_buf, a, b, q);
            while (code == 4 && num_tests < max_tests) begin
                names[num_tests] = string'(name_buf);
                dividends[num_tests] = a;
                divisors[num_tests] = b;
                expected_q[num_tests] = q;
                num_tests++;
                code = $fscanf(fd, "%s %h %h %h\n", name_buf, a, b, q);
            end
            $fclose(fd);
            if (num_tests == 0) begin
                $display("the vector file holds no usable test lines");
                aborted = 1'b1;
                fail_count++;
            end
        end
    endtask

    task automatic check_value(input string test_name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERROR %s expected %h actual %h", test_name, exp_v, act_v);
            fail_count++;
        end else begin
            $display("ok    %s value %h", test_name, act_v);
            pass_count++;
        end
    endtask

    task automatic write_pair(input int idx);
        int waited;
        waited = 0;
        while (in_full && waited < wait_limit && !aborted) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (!aborted) begin
            if (in_full) begin
                $display("timeout: the input FIFO stayed full before test %s", names[idx]);
                aborted = 1'b1;
                fail_count++;
            end else begin
                in_dividend = dividends[idx];
                in_divisor = divisors[idx];
                in_wr_en = 1'b1;
                @(posedge clock);
                #1;
                in_wr_en = 1'b0;
            end
        end
    endtask

    task automatic read_result(input string test_name, input logic [31:0] exp_q);
        int waited;
        logic [31:0] actual;
        waited = 0;
        while (out_empty && waited < wait_limit && !aborted) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (!aborted) begin
            if (out_empty) begin
                $display("timeout: no quotient came out for test %s", test_name);
                aborted = 1'b1;
                fail_count++;
            end else begin
                actual = out_quotient; // fwft head word
                out_rd_en = 1'b1;
                @(posedge clock);
                #1;
                out_rd_en = 1'b0;
                check_value(test_name, exp_q, actual);
            end
        end
    endtask

    task automatic feed_pairs();
        for (int i = 0; i < num_tests && !aborted; i++) begin
            write_pair(i);
        end
    endtask

    // mode 0 random pacing, 1 stall until the divider is held, 2 full speed
    task automatic drain_results(input string phase, input int mode);
        int delay;
        int waited;
        int held;
        waited = 0;
        held = 0;
        if (mode == 1) begin
            // in_full only stays high once the full output FIFO holds the divider
            while (held < stall_run && waited < fill_limit && !aborted) begin
                @(posedge clock);
                #1;
                waited++;
                if (in_full) begin
                    held++;
                end else begin
                    held = 0;
                end
            end
            if (held < stall_run && !aborted) begin
                $display("timeout: the input FIFO never stayed full while reading was stalled");
                aborted = 1'b1;
                fail_count++;
            end
        end
        for (int i = 0; i < num_tests && !aborted; i++) begin
            if (mode == 0) begin
                delay = $unsigned($random(seed)) % 61;
                repeat (delay) begin
                    @(posedge clock);
                    #1;
                end
            end
            read_result({phase, "/", names[i]}, expected_q[i]);
        end
    endtask

    task automatic run_phase(input string phase, input int mode);
        fork
            feed_pairs();
            drain_results(phase, mode);
        join
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        in_wr_en = 1'b0;
        in_dividend = '0;
        in_divisor = '0;
        out_rd_en = 1'b0;
        pass_count = 0;
        fail_count = 0;
        aborted = 1'b0;
        seed = 26;
        num_tests = 0;

        load_vectors();

        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        check_value("reset/in_full", 32'd0, 32'(in_full));
        check_value("reset/out_empty", 32'd1, 32'(out_empty));

        if (!aborted) begin
            run_phase("stream", 0);
        end
        if (!aborted) begin
            run_phase("stall", 1);
        end
        if (!aborted) begin
            run_phase("burst", 2);
            repeat (`D_WIDTH + `Q_BITS + 2) begin // room for a stray extra result
                @(posedge clock);
            end
            #1;
            check_value("burst/out_empty", 32'd1, 32'(out_empty)); // nothing left over
            check_value("burst/in_full", 32'd0, 32'(in_full));
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && !aborted) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== divider_top.sv ====
`default_nettype none

`include "divider_params.svh"

module divider_top (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         in_wr_en,
    input  wire signed [`D_WIDTH-1:0]   in_dividend,
    input  wire signed [`D_WIDTH-1:0]   in_divisor,
    output logic                        in_full,
    input  wire                         out_rd_en,
    output logic signed [`D_WIDTH-1:0]  out_quotient,
    output logic                        out_empty
);

    divider_pkg::operand_pair_t in_pair;
    divider_pkg::operand_pair_t div_operands;
    divider_pkg::quotient_t div_quotient;

    logic div_in_empty;
    logic div_rd_en;
    logic div_out_full;
    logic div_wr_en;

    always_comb begin
        in_pair.dividend = in_dividend;
        in_pair.divisor = in_divisor;
    end

    fifo #(
        .payload_t(divider_pkg::operand_pair_t),
        .depth(`FIFO_DEPTH)
    ) input_fifo (
        .clock(clock),
        .reset(reset),
        .wr_en(in_wr_en),
        .din(in_pair),
        .full(in_full),
        .rd_en(div_rd_en),
        .empty(div_in_empty),
        .dout(div_operands)
    );

    fixed_divider divider (
        .clock(clock),
        .reset(reset),
        .operands(div_operands),
        .in_empty(div_in_empty),
        .in_rd_en(div_rd_en),
        .out_wr_en(div_wr_en),
        .quotient(div_quotient),
        .out_full(div_out_full)
    );

    fifo #(
        .payload_t(divider_pkg::quotient_t),
        .depth(`FIFO_DEPTH)
    ) output_fifo (
        .clock(clock),
        .reset(reset),
        .wr_en(div_wr_en),
        .din(div_quotient),
        .full(div_out_full),
        .rd_en(out_rd_en),
        .empty(out_empty),
        .dout(out_quotient)
    );

endmodule

`default_nettype wire

// ==== fifo.sv ====
`default_nettype none

module fifo #(
    parameter type payload_t = logic [31:0],
    parameter int depth = 8
) (
    input  wire      clock,
    input  wire      reset,
    input  wire      wr_en,
    input  payload_t din,
    output logic     full,
    input  wire      rd_en,
    output logic     empty,
    output payload_t dout
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic do_write;
    logic do_read;

    // wrap explicitly so any depth works
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_write = wr_en && !full;
    assign do_read = rd_en && !empty;

    assign full = (count == cnt_w'(depth));
    assign empty = (count == '0);
    assign dout = mem[rd_ptr]; // first word falls through

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== fixed_divider.sv ====
`default_nettype none

`include "divider_params.svh"

module fixed_divider (
    input  wire                        clock,
    input  wire                        reset,
    input  divider_pkg::operand_pair_t operands,
    input  wire                        in_empty,
    output logic                       in_rd_en,
    output logic                       out_wr_en,
    output divider_pkg::quotient_t     quotient,
    input  wire                        out_full
);

    localparam int ed_width = `D_WIDTH + `Q_BITS + 1; // expanded working width
    localparam int cnt_w = $clog2(ed_width);

    typedef enum logic [1:0] {
        idle,
        iterate,
        write
    } state_t;

    state_t state;

    logic [cnt_w-1:0] count;
    logic dividend_neg;
    logic divisor_neg;
    logic [`D_WIDTH-1:0] divisor_mag;

    // partial remainder in [2*ed_width:ed_width], quotient bits below
    logic [2*ed_width:0] aq;

    logic [`D_WIDTH-1:0] dividend_abs;
    logic [`D_WIDTH-1:0] divisor_abs;
    logic [ed_width-1:0] load_word;
    logic [ed_width:0] divisor_ext;
    logic [ed_width:0] acc_shifted;
    logic [ed_width:0] acc_next;
    logic [`D_WIDTH-1:0] q_mag;

    assign dividend_abs = operands.dividend[`D_WIDTH-1] ? -operands.dividend : operands.dividend;
    assign divisor_abs = operands.divisor[`D_WIDTH-1] ? -operands.divisor : operands.divisor;

    // scaled dividend plus half the divisor for round to nearest
    assign load_word = (ed_width'(dividend_abs) << `Q_BITS) + ed_width'(divisor_abs >> 1);

    assign divisor_ext = (ed_width + 1)'(divisor_mag);

    // one non-restoring step
    assign acc_shifted = aq[2*ed_width-1:ed_width-1];

    always_comb begin
        if (aq[2*ed_width]) begin
            acc_next = acc_shifted + divisor_ext; // remainder negative
        end else begin
            acc_next = acc_shifted - divisor_ext;
        end
    end

    assign q_mag = aq[`D_WIDTH-1:0]; // keep low D_WIDTH bits

    always_comb begin
        if (dividend_neg ^ divisor_neg) begin
            quotient = -q_mag;
        end else begin
            quotient = q_mag;
        end
    end

    assign in_rd_en = (state == idle) && !in_empty;
    assign out_wr_en = (state == write) && !out_full;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
            count <= '0;
            dividend_neg <= 1'b0;
            divisor_neg <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (!in_empty) begin
                        dividend_neg <= operands.dividend[`D_WIDTH-1];
                        divisor_neg <= operands.divisor[`D_WIDTH-1];
                        count <= '0;
                        state <= iterate;
                    end
                end
                iterate: begin
                    count <= count + 1'b1;
                    if (count == cnt_w'(ed_width - 1)) begin
                        state <= write;
                    end
                end
                write: begin
                    if (!out_full) begin
                        dividend_neg <= 1'b0;
                        divisor_neg <= 1'b0;
                        state <= idle;
                    end // held under back-pressure
                end
                default: state <= idle;
            endcase
        end
    end

    // load on pop, one step per iterate cycle
    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            divisor_mag <= divisor_abs;
            aq <= {(ed_width + 1)'(0), load_word};
        end else if (state == iterate) begin
            aq <= {acc_next, aq[ed_width-2:0], ~acc_next[ed_width]};
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module divider_tb -f sim.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vdivider_tb > sim.log 2>&1 || true
cat sim.log

grep -q "Regression passed" sim.log \
    && { echo "simulation result: pass"; exit 0; } \
    || { echo "simulation result: fail"; exit 1; }

// ==== sim.f ====
+incdir+.
divider_pkg.sv
fifo.sv
fixed_divider.sv
divider_top.sv
divider_tb.sv
